// ==== hdl/byte_deserializer.sv ====
// Deserializer pairing link bytes into words, checking parity and counting drops
module byte_deserializer
   import link_pkg::*;
(
   input  logic   clk,
   input  logic   reset,
   input  byte_t  rx_byte,
   input  logic   rx_valid,
   input  logic   rx_first,               // Byte is the high half
   input  logic   rx_parity,
   input  logic   fifo_full,              // RX FIFO cannot take a word
   output word_t  wdata,
   output logic   wen,                    // One cycle after the low byte
   output count_t drop_count              // Wraps
);

   byte_t hi_q;                           // Held high byte
   logic  hi_ok;                          // High byte parity good
   logic  pending;                        // High byte waiting for its pair
   logic  rx_ok;                          // Parity of current byte good

   // Even parity check over nine bits
   assign rx_ok = ~^{rx_byte, rx_parity};

   // High byte and assembled word payload
   always_ff @(posedge clk) begin
      if (rx_valid && rx_first) begin
         hi_q  <= rx_byte;
         hi_ok <= rx_ok;
      end
      if (rx_valid && !rx_first) begin
         wdata <= {hi_q, rx_byte};
      end
   end

   // Pairing control, write strobe and drop count
   always_ff @(posedge clk) begin
      if (reset) begin
         pending    <= 1'b0;
         wen        <= 1'b0;
         drop_count <= '0;
      end else begin
         wen <= 1'b0;
         if (rx_valid && rx_first) begin
            pending <= 1'b1;
            if (pending) begin
               drop_count <= drop_count + 1'b1;    // Replaced an unpaired high byte
            end
         end else if (rx_valid) begin
            pending <= 1'b0;
            if (pending && hi_ok && rx_ok && !fifo_full) begin
               wen <= 1'b1;               // Word accepted
            end else begin
               drop_count <= drop_count + 1'b1;    // Bad parity, full or orphan low byte
            end
         end
      end
   end

endmodule

// ==== hdl/byte_link.sv ====
// Byte link top level with TX FIFO, TX FSM, serializer, deserializer and RX FIFO
module byte_link
   import link_pkg::*;
#(
   parameter int FIFO_AW = FIFO_AW_DEFAULT  // Address width of both FIFOs
) (
   input  logic   clk,
   input  logic   reset,
   // Writer side
   input  word_t  in_data,
   input  logic   in_valid,               // Write strobe
   output logic   in_full,
   // Transmit link
   input  logic   tx_hold,                // Pause between words
   output byte_t  tx_byte,
   output logic   tx_valid,
   output logic   tx_first,
   output logic   tx_parity,
   // Receive link
   input  byte_t  rx_byte,
   input  logic   rx_valid,
   input  logic   rx_first,
   input  logic   rx_parity,
   // Reader side
   output word_t  out_data,               // Head word, combinational
   input  logic   out_ren,                // Read pulse
   output logic   out_empty,
   output logic   out_full,
   output count_t drop_count
);

   word_t tx_word;                        // TX FIFO head to serializer
   logic  in_empty;                       // TX FIFO empty
   logic  load;                           // Pop and capture
   logic  send_lo;                        // Low byte request
   word_t rx_word;                        // Assembled word
   logic  rx_wen;                         // RX FIFO write

   // Transmit buffer
   syncfifo #(
      .AW(FIFO_AW),
      .DW(DATA_W)
   ) u_tx_fifo (
      .clk(clk),
      .reset(reset),
      .wdata(in_data),
      .wen(in_valid),
      .ren(load),
      .rdata(tx_word),
      .empty(in_empty),
      .full(in_full)
   );

   link_tx_ctrl u_tx_ctrl (
      .clk(clk),
      .reset(reset),
      .fifo_empty(in_empty),
      .tx_hold(tx_hold),
      .load(load),
      .send_lo(send_lo)
   );

   byte_serializer u_ser (
      .clk(clk),
      .reset(reset),
      .word_in(tx_word),
      .load(load),
      .send_lo(send_lo),
      .tx_byte(tx_byte),
      .tx_valid(tx_valid),
      .tx_first(tx_first),
      .tx_parity(tx_parity)
   );

   byte_deserializer u_deser (
      .clk(clk),
      .reset(reset),
      .rx_byte(rx_byte),
      .rx_valid(rx_valid),
      .rx_first(rx_first),
      .rx_parity(rx_parity),
      .fifo_full(out_full),
      .wdata(rx_word),
      .wen(rx_wen),
      .drop_count(drop_count)
   );

   // Receive buffer
   syncfifo #(
      .AW(FIFO_AW),
      .DW(DATA_W)
   ) u_rx_fifo (
      .clk(clk),
      .reset(reset),
      .wdata(rx_word),
      .wen(rx_wen),
      .ren(out_ren),
      .rdata(out_data),
      .empty(out_empty),
      .full(out_full)
   );

endmodule

// ==== hdl/byte_serializer.sv ====
// Serializer holding the popped word and driving registered link byte, marker and parity
module byte_serializer
   import link_pkg::*;
(
   input  logic  clk,
   input  logic  reset,
   input  word_t word_in,                 // TX FIFO head
   input  logic  load,                    // Capture word, emit high byte
   input  logic  send_lo,                 // Emit low byte of held word
   output byte_t tx_byte,
   output logic  tx_valid,
   output logic  tx_first,                // High only with the high byte
   output logic  tx_parity                // Even parity over byte plus bit
);

   word_t word_q;                         // Word in flight

   // Payload registers
   always_ff @(posedge clk) begin
      if (load) begin
         word_q  <= word_in;
         tx_byte <= word_in[DATA_W-1 -: BYTE_W];
      end else if (send_lo) begin
         tx_byte <= word_q[BYTE_W-1:0];
      end
   end

   // Link control bits
   always_ff @(posedge clk) begin
      if (reset) begin
         tx_valid  <= 1'b0;
         tx_first  <= 1'b0;
         tx_parity <= 1'b0;
      end else if (load) begin
         tx_valid  <= 1'b1;
         tx_first  <= 1'b1;              // Marks start of word
         tx_parity <= ^word_in[DATA_W-1 -: BYTE_W];
      end else if (send_lo) begin
         tx_valid  <= 1'b1;
         tx_first  <= 1'b0;
         tx_parity <= ^word_q[BYTE_W-1:0];
      end else begin
         tx_valid <= 1'b0;                // Idle link cycle
         tx_first <= 1'b0;
      end
   end

endmodule

// ==== hdl/link_pkg.sv ====
// Link package with word, byte and counter types, default widths and the TX state enum
package link_pkg;

   // Widths
   localparam int DATA_W = 16;            // Data word width
   localparam int BYTE_W = 8;             // Link byte width
   localparam int CNT_W = 8;              // Dropped-word counter width

   // FIFO address width, depth is 2**AW
   localparam int FIFO_AW_DEFAULT = 5;    // 32 entries

   // Types that carry meaning on the link
   typedef logic [DATA_W-1:0] word_t;     // One data word
   typedef logic [BYTE_W-1:0] byte_t;     // One link byte
   typedef logic [CNT_W-1:0] count_t;     // Drop counter, wraps

   // Transmit sequencing states
   typedef enum logic [1:0] {
      TX_IDLE = 2'd0,                     // No word in flight
      TX_HI = 2'd1,                       // High byte on the link
      TX_LO = 2'd2                        // Low byte on the link
   } tx_state_t;

endpackage

// ==== hdl/link_tx_ctrl.sv ====
// Transmit FSM that pops words from the TX FIFO and sequences high then low byte
module link_tx_ctrl
   import link_pkg::*;
(
   input  logic clk,
   input  logic reset,
   input  logic fifo_empty,               // TX FIFO has no word
   input  logic tx_hold,                  // Remote asks to pause between words
   output logic load,                     // Pop word, send high byte next cycle
   output logic send_lo                   // Send low byte next cycle
);

   tx_state_t state;
   tx_state_t state_next;
   logic      can_start;                  // Word boundary, a new word may begin

   // A new word may start from idle or right behind a low byte
   assign can_start = (state == TX_IDLE) || (state == TX_LO);

   // Hold is only looked at when a word is about to start
   assign load = can_start && !fifo_empty && !tx_hold;

   // Second byte always follows the first, hold cannot split a word
   assign send_lo = (state == TX_HI);

   // Next state
   always_comb begin
      state_next = state;
      case (state)
         TX_IDLE: begin
            if (load) begin
               state_next = TX_HI;        // High byte goes out next
            end
         end
         TX_HI: begin
            state_next = TX_LO;           // Low byte unconditionally
         end
         TX_LO: begin
            if (load) begin
               state_next = TX_HI;        // Back to back words
            end else begin
               state_next = TX_IDLE;      // Empty or held
            end
         end
         default: begin
            state_next = TX_IDLE;         // Recover from illegal code
         end
      endcase
   end

   // State register
   always_ff @(posedge clk) begin
      if (reset) begin
         state <= TX_IDLE;
      end else begin
         state <= state_next;
      end
   end

endmodule

// ==== hdl/syncfifo.sv ====
// Small synchronous FIFO with register-array memory, pointers, count and full/empty flags
module syncfifo #(
   parameter int AW = 5,                  // Address width, depth 2**AW
   parameter int DW = 16                  // Data width
) (
   input  logic          clk,
   input  logic          reset,
   input  logic [DW-1:0] wdata,
   input  logic          wen,             // No write when full
   input  logic          ren,             // No read when empty
   output logic [DW-1:0] rdata,           // Head of queue, combinational
   output logic          empty,
   output logic          full
);

   localparam int DEPTH = 2 ** AW;

   logic [DW-1:0] mem [DEPTH];            // Storage array
   logic [AW-1:0] waddr;                  // Next slot to write
   logic [AW-1:0] raddr;                  // Current head slot
   logic [AW:0]   count;                  // Entries stored, 0..DEPTH

   // Pointer, count and flag update
   always_ff @(posedge clk) begin
      if (reset) begin
         waddr <= '0;
         raddr <= '0;
         count <= '0;
         empty <= 1'b1;
         full  <= 1'b0;
      end else begin
         if (wen && ren) begin
            // Occupancy unchanged, flags hold
            waddr <= waddr + 1'b1;
            raddr <= raddr + 1'b1;
         end else if (wen) begin
            waddr <= waddr + 1'b1;
            count <= count + 1'b1;
            empty <= 1'b0;               // Something stored now
            if (count == (AW+1)'(DEPTH - 1)) begin
               full <= 1'b1;              // This write fills it
            end
         end else if (ren) begin
            raddr <= raddr + 1'b1;
            count <= count - 1'b1;
            full  <= 1'b0;               // A slot just freed
            if (count == (AW+1)'(1)) begin
               empty <= 1'b1;             // Last entry leaves
            end
         end
      end
   end

   // Memory write port
   always_ff @(posedge clk) begin
      if (wen) begin
         mem[waddr] <= wdata;
      end
   end

   // Combinational read at the head
   assign rdata = mem[raddr];

endmodule

// ==== tb.f ====
hdl/link_pkg.sv
hdl/syncfifo.sv
hdl/link_tx_ctrl.sv
hdl/byte_serializer.sv
hdl/byte_deserializer.sv
hdl/byte_link.sv
tests/byte_link_properties.sv
tests/byte_link_tb.sv

// ==== tests/byte_link_properties.sv ====
// Concurrent assertions on link framing, RX FIFO flags and reset state, bound to byte_link
module byte_link_properties (
   input logic clk,
   input logic reset,
   input logic tx_valid,
   input logic tx_first,
   input logic out_full,
   input logic out_empty
);

   // Marker only rides on a valid byte
   a_first_has_valid: assert property (@(posedge clk) disable iff (reset)
      tx_first |-> tx_valid)
      else $error("tx_first high while tx_valid is low");

   // High byte is always followed by its low byte
   a_low_follows_high: assert property (@(posedge clk) disable iff (reset)
      tx_first |=> (tx_valid && !tx_first))
      else $error("high byte not followed by a low byte on the next cycle");

   // RX FIFO flags are exclusive
   a_rx_flags_exclusive: assert property (@(posedge clk) disable iff (reset)
      !(out_full && out_empty))
      else $error("out_full and out_empty high together");

   // Link idle right out of reset
   a_idle_after_reset: assert property (@(posedge clk)
      reset |=> !tx_valid)
      else $error("tx_valid high in the cycle after reset");

endmodule

bind byte_link byte_link_properties u_props (
   .clk(clk),
   .reset(reset),
   .tx_valid(tx_valid),
   .tx_first(tx_first),
   .out_full(out_full),
   .out_empty(out_empty)
);

// ==== tests/byte_link_tb.sv ====
// Testbench for byte_link with loopback, parity corruption, LFSR data, reference model and checks
module byte_link_tb
   import link_pkg::*;
();

   localparam int AW = 5;
   localparam int DEPTH = 2 ** AW;               // RX FIFO capacity
   localparam int TOTAL_WORDS = 1 + 20 + 10 + 6 + 35 + 32;
   localparam int NUM_TESTS = 6;
   localparam int CYCLE_LIMIT = 4 * TOTAL_WORDS + 40 * NUM_TESTS + 20;

   logic   clk;
   logic   reset;
   word_t  in_data;
   logic   in_valid;
   logic   in_full;
   logic   tx_hold;
   byte_t  tx_byte;
   logic   tx_valid;
   logic   tx_first;
   logic   tx_parity;
   byte_t  rx_byte;
   logic   rx_valid;
   logic   rx_first;
   logic   rx_parity;
   word_t  out_data;
   logic   out_ren;
   logic   out_empty;
   logic   out_full;
   count_t drop_count;

   logic [31:0] lfsr;                            // Data generator state
   word_t       tx_q [$];                        // Written, not yet seen on the link
   word_t       exp_q [$];                       // Expected at out_data, in order
   word_t       cur_word;                        // Word whose bytes are on the link
   logic        expect_lo;                       // High byte seen and low byte due
   logic        pair_bad;                        // A byte of this word was corrupted
   logic        reading;                         // Reader enabled
   logic        corrupt;                         // Invert parity of this link byte
   int          model_count;                     // Modelled RX FIFO occupancy
   int          expected_drops;
   int          byte_index;                      // Link bytes sent so far
   int          corrupt_a;
   int          corrupt_b;
   int          cycle_count = 0;
   int          checks;
   int          errors;
   int          tests_run;
   int          test_errors_start;
   count_t      drops_start;
   string       test_name;

   byte_link #(
      .FIFO_AW(AW)
   ) u_dut (
      .clk(clk),
      .reset(reset),
      .in_data(in_data),
      .in_valid(in_valid),
      .in_full(in_full),
      .tx_hold(tx_hold),
      .tx_byte(tx_byte),
      .tx_valid(tx_valid),
      .tx_first(tx_first),
      .tx_parity(tx_parity),
      .rx_byte(rx_byte),
      .rx_valid(rx_valid),
      .rx_first(rx_first),
      .rx_parity(rx_parity),
      .out_data(out_data),
      .out_ren(out_ren),
      .out_empty(out_empty),
      .out_full(out_full),
      .drop_count(drop_count)
   );

   // Loopback with the parity flipped on the chosen byte numbers
   assign corrupt   = tx_valid && (byte_index == corrupt_a || byte_index == corrupt_b);
   assign rx_byte   = tx_byte;
   assign rx_valid  = tx_valid;
   assign rx_first  = tx_first;
   assign rx_parity = tx_parity ^ corrupt;

   initial clk = 1'b0;
   always #4 clk = ~clk;                         // 8 unit period

   // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h8020_0003;
      end
      return s >> 1;
   endfunction

   // Even parity bit counted one bit at a time
   function automatic logic even_parity(input byte_t b);
      logic p;
      int   i;
      p = 1'b0;
      for (i = 0; i < 8; i++) begin
         if (b[i]) begin
            p = !p;                              // Toggle per one
         end
      end
      return p;
   endfunction

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      if (expected !== actual) begin
         errors++;
         $display("** Error %s %s: expected %h, actual %h", test_name, what, expected, actual);
      end
   endtask

   task automatic gen_word(output word_t w);
      int i;
      for (i = 0; i < DATA_W; i++) begin
         w[i] = lfsr[0];                         // One step per bit taken
         lfsr = lfsr_next(lfsr);
      end
   endtask

   task automatic send_word(input word_t w);
      @(negedge clk);
      while (in_full) begin
         in_valid <= 1'b0;                       // Writer backs off
         @(negedge clk);
      end
      in_valid <= 1'b1;
      in_data  <= w;
      tx_q.push_back(w);
   endtask

   task automatic send_random(input int n);
      word_t w;
      int    i;
      for (i = 0; i < n; i++) begin
         gen_word(w);
         send_word(w);
      end
   endtask

   task automatic stop_writes();
      @(negedge clk);
      in_valid <= 1'b0;
   endtask

   // All written words have crossed the link
   task automatic wait_sent();
      @(posedge clk);
      while (tx_q.size() != 0 || expect_lo) begin
         @(posedge clk);
      end
      repeat (3) @(posedge clk);                 // Last wen and drop update
      @(negedge clk);
   endtask

   // Link idle and every expected word read back
   task automatic drain_all();
      @(posedge clk);
      while (tx_q.size() != 0 || exp_q.size() != 0 || !out_empty || expect_lo) begin
         @(posedge clk);
      end
      repeat (3) @(posedge clk);
      @(negedge clk);
   endtask

   task automatic begin_test(input string name);
      @(negedge clk);
      test_name         = name;
      test_errors_start = errors;
      drops_start       = drop_count;
   endtask

   task automatic finish_test();
      drain_all();
      check_value("drop count", 32'(8'(expected_drops)), 32'(drop_count));
      $display("Test %-18s done, %0d errors", test_name, errors - test_errors_start);
      tests_run++;
   endtask

   task automatic single_word();
      begin_test("single_word");
      send_word(16'hc3a5);
      stop_writes();
      drain_all();
      check_value("words dropped", 0, 32'(8'(drop_count - drops_start)));
      finish_test();
   endtask

   task automatic burst_order();
      begin_test("burst_order");
      send_random(20);                           // Back to back strobes
      stop_writes();
      finish_test();
   endtask

   task automatic hold_and_resume();
      begin_test("hold_and_resume");
      send_random(10);
      stop_writes();
      tx_hold <= 1'b1;                           // Word in flight may finish
      repeat (12) begin
         @(negedge clk);
         check_value("tx_first during hold", 0, 32'(tx_first));
      end
      check_value("words held back", 1, 32'(tx_q.size() != 0));
      tx_hold <= 1'b0;
      finish_test();
   endtask

   task automatic parity_corruption();
      begin_test("parity_corruption");
      corrupt_a <= byte_index + 4;               // High byte of word 2
      corrupt_b <= byte_index + 9;               // Low byte of word 4
      send_random(6);
      stop_writes();
      drain_all();
      check_value("words dropped", 2, 32'(8'(drop_count - drops_start)));
      corrupt_a <= -1;
      corrupt_b <= -1;
      finish_test();
   endtask

   task automatic receive_overflow();
      begin_test("receive_overflow");
      reading <= 1'b0;                           // Let the RX FIFO fill
      send_random(35);
      stop_writes();
      wait_sent();
      check_value("out_full after overflow", 1, 32'(out_full));
      check_value("words dropped", 3, 32'(8'(drop_count - drops_start)));
      reading <= 1'b1;
      finish_test();
   endtask

   task automatic transmit_fill();
      begin_test("transmit_fill");
      tx_hold <= 1'b1;
      send_random(DEPTH);
      stop_writes();
      check_value("in_full after fill", 1, 32'(in_full));
      tx_hold <= 1'b0;                           // Release and drain in order
      finish_test();
   endtask

   always @(posedge clk) begin
      if (reset) begin
         byte_index <= 0;
      end else if (tx_valid) begin
         byte_index <= byte_index + 1;
      end
   end

   // Link monitor, reference model and reader
   always @(negedge clk) begin
      if (reset) begin
         expect_lo      = 1'b0;
         pair_bad       = 1'b0;
         model_count    = 0;
         expected_drops = 0;
         out_ren       <= 1'b0;
      end else begin
         if (expect_lo) begin
            check_value("low byte follows high byte", 1, 32'(tx_valid && !tx_first));
         end
         if (tx_valid) begin
            if (tx_first) begin
               if (tx_q.size() == 0) begin
                  errors++;
                  $display("Error in %s: high byte on the link with no word written", test_name);
               end else begin
                  cur_word  = tx_q[0];
                  check_value("high byte", 32'(cur_word[15:8]), 32'(tx_byte));
                  check_value("high byte parity", 32'(even_parity(cur_word[15:8])),
                              32'(tx_parity));
                  pair_bad  = corrupt;
                  expect_lo = 1'b1;
               end
            end else if (expect_lo) begin
               check_value("low byte", 32'(cur_word[7:0]), 32'(tx_byte));
               check_value("low byte parity", 32'(even_parity(cur_word[7:0])),
                           32'(tx_parity));
               pair_bad  = pair_bad || corrupt;
               expect_lo = 1'b0;
               void'(tx_q.pop_front());
               if (!pair_bad && model_count < DEPTH) begin
                  exp_q.push_back(cur_word);     // Accepted into RX FIFO
                  model_count++;
               end else begin
                  expected_drops++;              // Bad parity or RX FIFO full
               end
            end else begin
               errors++;
               $display("Error in %s: low byte on the link without a high byte", test_name);
            end
         end
         if (reading && !out_empty) begin
            out_ren <= 1'b1;
            if (exp_q.size() == 0) begin
               errors++;
               $display("Error in %s: DUT delivered a word that was not expected", test_name);
            end else begin
               check_value("out_data", 32'(exp_q.pop_front()), 32'(out_data));
               model_count--;
            end
         end else begin
            out_ren <= 1'b0;
         end
      end
   end

   // Watchdog
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count > CYCLE_LIMIT) begin
         $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   initial begin
      reset     = 1'b1;
      in_data   = '0;
      in_valid  = 1'b0;
      tx_hold   = 1'b0;
      out_ren   = 1'b0;
      reading   = 1'b0;
      corrupt_a = -1;
      corrupt_b = -1;
      lfsr      = 32'h131e_409f;
      checks    = 0;
      errors    = 0;
      tests_run = 0;
      test_name = "reset";
      repeat (3) @(posedge clk);                 // Three reset cycles
      @(negedge clk);
      reset   <= 1'b0;
      reading <= 1'b1;
      single_word();
      burst_order();
      hold_and_resume();
      parity_corruption();
      receive_overflow();
      transmit_fill();
      $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule
